// ==== Makefile ====
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module outputPortTb \
		-f all.f -o outputPortSim

run: compile
	./obj_dir/outputPortSim > $(LOG) 2>&1; cat $(LOG)
	grep -qF '*** PASSED ***' $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== all.f ====
common/nocPkg.sv
arbiter/portTimer.sv
arbiter/switchArbiter.sv
hdl/flitMux.sv
hdl/outputPort.sv
bench/outputPort_assert.sv
bench/outputPortTb.sv

// ==== arbiter/portTimer.sv ====
module portTimer
(
  input  logic                           clk,
  input  logic                           rst,
  input  nocPkg::flitIdT                 flitId,
  input  logic [nocPkg::lengthWidth-1:0] length,
  input  logic                           runTimer,
  output logic                           timesUp
);

  logic [nocPkg::lengthWidth-1:0] limit;
  logic [nocPkg::lengthWidth-1:0] count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= '0;
      count <= '0;
    end
    else
    begin
      // The header flit carries the packet length.
      if (flitId == nocPkg::flitHeader)
      begin
        limit <= length;
      end
      // Count only while the arbiter keeps this port granted.
      if (runTimer)
      begin
        count <= count + 1'b1;
      end
      else
      begin
        count <= '0;
      end
    end
  end

  assign timesUp = (count == limit);

endmodule

// ==== arbiter/switchArbiter.sv ====
module switchArbiter
(
  input  logic                           clk,
  input  logic                           rst,
  input  nocPkg::flitIdT                 lFlitId,
  input  nocPkg::flitIdT                 nFlitId,
  input  nocPkg::flitIdT                 eFlitId,
  input  nocPkg::flitIdT                 wFlitId,
  input  nocPkg::flitIdT                 sFlitId,
  input  logic [nocPkg::lengthWidth-1:0] lLength,
  input  logic [nocPkg::lengthWidth-1:0] nLength,
  input  logic [nocPkg::lengthWidth-1:0] eLength,
  input  logic [nocPkg::lengthWidth-1:0] wLength,
  input  logic [nocPkg::lengthWidth-1:0] sLength,
  input  logic                           lReq,
  input  logic                           nReq,
  input  logic                           eReq,
  input  logic                           wReq,
  input  logic                           sReq,
  output nocPkg::arbStateT               grant
);

  logic [nocPkg::numPorts-1:0] reqVec;
  logic [nocPkg::numPorts-1:0] timesUp;
  logic [nocPkg::numPorts-1:0] runTimer;
  nocPkg::arbStateT            nextState;
  nocPkg::portT                curPort;

  // Bit order follows portT.
  assign reqVec = {sReq, wReq, eReq, nReq, lReq};

  // First requester in rotating order, looking at span ports from start.
  function automatic nocPkg::arbStateT firstReq
  (
    input logic [nocPkg::numPorts-1:0] req,
    input int unsigned                 start,
    input int unsigned                 span
  );
    nocPkg::arbStateT pick;
    logic             found;
    int unsigned      idx;
    pick = nocPkg::stIdle;
    found = 1'b0;
    for (int i = 0; i < nocPkg::numPorts; i++)
    begin
      idx = (start + i) % nocPkg::numPorts;
      if (!found && (i < span) && req[idx])
      begin
        pick = nocPkg::arbStateT'(6'b000010 << idx);
        found = 1'b1;
      end
    end
    return pick;
  endfunction

  // Index of the port that holds the grant.
  always_comb
  begin
    curPort = nocPkg::portLocal;
    for (int k = 0; k < nocPkg::numPorts; k++)
    begin
      if (grant[k+1])
      begin
        curPort = nocPkg::portT'(k);
      end
    end
  end

  always_comb
  begin
    runTimer = '0;
    nextState = nocPkg::stIdle;
    case (grant)
      nocPkg::stIdle:
      begin
        nextState = firstReq(reqVec, 0, nocPkg::numPorts);
      end
      nocPkg::stLocal, nocPkg::stNorth, nocPkg::stEast, nocPkg::stWest, nocPkg::stSouth:
      begin
        if (reqVec[curPort] && !timesUp[curPort])
        begin
          runTimer[curPort] = 1'b1;
          nextState = grant;
        end
        else
        begin
          // Search the other four ports, starting after the holder.
          nextState = firstReq(reqVec, curPort + 1, nocPkg::numPorts - 1);
        end
      end
      default:
      begin
        nextState = nocPkg::stIdle;
      end
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      grant <= nocPkg::stIdle;
    end
    else
    begin
      grant <= nextState;
    end
  end

  portTimer lTimer
  (
    .clk      (clk),
    .rst      (rst),
    .flitId   (lFlitId),
    .length   (lLength),
    .runTimer (runTimer[nocPkg::portLocal]),
    .timesUp  (timesUp[nocPkg::portLocal])
  );

  portTimer nTimer
  (
    .clk      (clk),
    .rst      (rst),
    .flitId   (nFlitId),
    .length   (nLength),
    .runTimer (runTimer[nocPkg::portNorth]),
    .timesUp  (timesUp[nocPkg::portNorth])
  );

  portTimer eTimer
  (
    .clk      (clk),
    .rst      (rst),
    .flitId   (eFlitId),
    .length   (eLength),
    .runTimer (runTimer[nocPkg::portEast]),
    .timesUp  (timesUp[nocPkg::portEast])
  );

  portTimer wTimer
  (
    .clk      (clk),
    .rst      (rst),
    .flitId   (wFlitId),
    .length   (wLength),
    .runTimer (runTimer[nocPkg::portWest]),
    .timesUp  (timesUp[nocPkg::portWest])
  );

  portTimer sTimer
  (
    .clk      (clk),
    .rst      (rst),
    .flitId   (sFlitId),
    .length   (sLength),
    .runTimer (runTimer[nocPkg::portSouth]),
    .timesUp  (timesUp[nocPkg::portSouth])
  );

endmodule

// ==== bench/outputPortTb.sv ====
module outputPortTb;

  logic                           clk;
  logic                           rst;
  logic [nocPkg::flitWidth-1:0]   flit [nocPkg::numPorts];
  nocPkg::flitIdT                 flitId [nocPkg::numPorts];
  logic [nocPkg::lengthWidth-1:0] len [nocPkg::numPorts];
  logic [nocPkg::numPorts-1:0]    req;
  nocPkg::arbStateT               grant;
  logic [nocPkg::flitWidth-1:0]   outFlit;
  logic                           outValid;

  // Reference model state.
  nocPkg::arbStateT               expGrant;
  logic                           expValid;
  logic [nocPkg::flitWidth-1:0]   expFlit;
  logic [nocPkg::lengthWidth-1:0] modelLimit [nocPkg::numPorts];
  logic [nocPkg::lengthWidth-1:0] modelCount [nocPkg::numPorts];

  logic checking;
  int   errorCount;
  int   errorsAtStart;
  int   passedTests;
  int   failedTests;
  int   cycleCount;
  // Tests take about 1500 cycles; the rest is margin.
  int   timeoutCycles = 4000;

  outputPort outputPort_inst
  (
    .clk      (clk),
    .rst      (rst),
    .lFlit    (flit[nocPkg::portLocal]),
    .nFlit    (flit[nocPkg::portNorth]),
    .eFlit    (flit[nocPkg::portEast]),
    .wFlit    (flit[nocPkg::portWest]),
    .sFlit    (flit[nocPkg::portSouth]),
    .lFlitId  (flitId[nocPkg::portLocal]),
    .nFlitId  (flitId[nocPkg::portNorth]),
    .eFlitId  (flitId[nocPkg::portEast]),
    .wFlitId  (flitId[nocPkg::portWest]),
    .sFlitId  (flitId[nocPkg::portSouth]),
    .lLength  (len[nocPkg::portLocal]),
    .nLength  (len[nocPkg::portNorth]),
    .eLength  (len[nocPkg::portEast]),
    .wLength  (len[nocPkg::portWest]),
    .sLength  (len[nocPkg::portSouth]),
    .lReq     (req[nocPkg::portLocal]),
    .nReq     (req[nocPkg::portNorth]),
    .eReq     (req[nocPkg::portEast]),
    .wReq     (req[nocPkg::portWest]),
    .sReq     (req[nocPkg::portSouth]),
    .grant    (grant),
    .outFlit  (outFlit),
    .outValid (outValid)
  );

  always #10 clk = ~clk;

  function automatic nocPkg::arbStateT stateOf(input int k);
    case (k)
      0: return nocPkg::stLocal;
      1: return nocPkg::stNorth;
      2: return nocPkg::stEast;
      3: return nocPkg::stWest;
      default: return nocPkg::stSouth;
    endcase
  endfunction

  function automatic int indexOf(input nocPkg::arbStateT s);
    case (s)
      nocPkg::stLocal: return 0;
      nocPkg::stNorth: return 1;
      nocPkg::stEast: return 2;
      nocPkg::stWest: return 3;
      default: return 4;
    endcase
  endfunction

  // Idle scans L, N, E, W, S; a holder keeps the grant until its time is up,
  // then the scan starts at the next port and puts the holder last.
  function automatic nocPkg::arbStateT refNextGrant(input nocPkg::arbStateT state,
    input logic [nocPkg::numPorts-1:0] r, input logic [nocPkg::numPorts-1:0] tu);
    nocPkg::arbStateT nxt;
    int               cur;
    int               idx;
    logic             found;
    nxt = nocPkg::stIdle;
    found = 1'b0;
    cur = (state == nocPkg::stIdle) ? nocPkg::numPorts - 1 : indexOf(state);
    if (state != nocPkg::stIdle && r[cur] && !tu[cur])
    begin
      nxt = state;
      found = 1'b1;
    end
    for (int i = 1; i <= nocPkg::numPorts; i++)
    begin
      idx = (cur + i) % nocPkg::numPorts;
      if (!found && r[idx] && (state == nocPkg::stIdle || idx != cur))
      begin
        nxt = stateOf(idx);
        found = 1'b1;
      end
    end
    return nxt;
  endfunction

  always @(posedge clk)
  begin : model
    logic [nocPkg::numPorts-1:0] tu;
    nocPkg::arbStateT            nxt;
    int                          cur;
    cur = -1;
    if (rst)
    begin
      expGrant = nocPkg::stIdle;
      expValid = 1'b0;
      expFlit = '0;
      for (int k = 0; k < nocPkg::numPorts; k++)
      begin
        modelLimit[k] = '0;
        modelCount[k] = '0;
      end
    end
    else
    begin
      for (int k = 0; k < nocPkg::numPorts; k++)
      begin
        tu[k] = (modelCount[k] == modelLimit[k]);
      end
      nxt = refNextGrant(expGrant, req, tu);
      expValid = 1'b0;
      if (expGrant != nocPkg::stIdle)
      begin
        cur = indexOf(expGrant);
        expValid = req[cur];
        expFlit = flit[cur];
      end
      for (int k = 0; k < nocPkg::numPorts; k++)
      begin
        if (flitId[k] == nocPkg::flitHeader)
        begin
          modelLimit[k] = len[k];
        end
        if (k == cur && req[k] && !tu[k])
        begin
          modelCount[k] = modelCount[k] + 1'b1;
        end
        else
        begin
          modelCount[k] = '0;
        end
      end
      expGrant = nxt;
    end
  end

  // Outputs are compared just after the rising edge.
  always @(posedge clk)
  begin
    #1;
    if (checking)
    begin
      assert (grant === expGrant)
      else
      begin
        $display("Fail at %0t: grant expected %b, got %b", $time, expGrant, grant);
        errorCount++;
      end
      assert (outValid === expValid)
      else
      begin
        $display("Fail at %0t: outValid expected %b, got %b", $time, expValid, outValid);
        errorCount++;
      end
      if (expValid)
      begin
        assert (outFlit === expFlit)
        else
        begin
          $display("Fail at %0t: outFlit expected %h, got %h", $time, expFlit, outFlit);
          errorCount++;
        end
      end
    end
  end

  always @(posedge clk)
  begin
    cycleCount++;
    if (cycleCount >= timeoutCycles)
    begin
      $display("Timeout: the tests did not finish within %0d cycles", timeoutCycles);
      $display("*** FAILED ***");
      $finish;
    end
  end

  task automatic clearInputs();
    req = '0;
    for (int k = 0; k < nocPkg::numPorts; k++)
    begin
      flit[k] = '0;
      flitId[k] = nocPkg::flitIdle;
      len[k] = '0;
    end
  endtask

  task automatic startTest();
    errorsAtStart = errorCount;
  endtask

  task automatic reportTest(input string name);
    if (errorCount == errorsAtStart)
    begin
      passedTests++;
      $display("Test %s: ok", name);
    end
    else
    begin
      failedTests++;
      $display("Test %s: %0d errors", name, errorCount - errorsAtStart);
    end
  endtask

  task automatic checkGrant(input nocPkg::arbStateT expected);
    assert (grant == expected)
    else
    begin
      $display("Fail at %0t: grant expected %b, got %b", $time, expected, grant);
      errorCount++;
    end
  endtask

  task automatic waitForGrant(input nocPkg::arbStateT target);
    int waited;
    waited = 0;
    while (grant != target && waited < 20)
    begin
      @(negedge clk);
      waited++;
    end
    assert (grant == target)
    else
    begin
      $display("Error at %0t: grant never reached %s", $time, target.name());
      errorCount++;
    end
  endtask

  initial
  begin
    int k;
    int n;
    int held;
    void'($urandom(32'h49f65b32));
    clk = 1'b0;
    rst = 1'b1;
    checking = 1'b0;
    errorCount = 0;
    passedTests = 0;
    failedTests = 0;
    cycleCount = 0;
    clearInputs();
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    checking = 1'b1;

    startTest();
    repeat (10) @(negedge clk);
    reportTest("reset and idle");

    startTest();
    for (int i = 0; i < 50; i++)
    begin
      req = nocPkg::numPorts'($urandom_range(31, 1));
      @(negedge clk);
      req = '0;
      repeat (3) @(negedge clk);
    end
    reportTest("fixed priority from idle");

    // All limits are still 0, so each holder keeps the grant one cycle.
    startTest();
    req = '1;
    repeat (7) @(negedge clk);
    waitForGrant(nocPkg::stWest);
    @(negedge clk);
    checkGrant(nocPkg::stSouth);
    waitForGrant(nocPkg::stWest);
    req[nocPkg::portLocal] = 1'b0;
    req[nocPkg::portSouth] = 1'b0;
    @(negedge clk);
    checkGrant(nocPkg::stNorth);
    // With North dropped as well, West has to wrap round to East.
    waitForGrant(nocPkg::stWest);
    req[nocPkg::portNorth] = 1'b0;
    @(negedge clk);
    checkGrant(nocPkg::stEast);
    waitForGrant(nocPkg::stWest);
    req = '0;
    @(negedge clk);
    checkGrant(nocPkg::stIdle);
    repeat (2) @(negedge clk);
    reportTest("rotation");

    startTest();
    for (int i = 0; i < 8; i++)
    begin
      clearInputs();
      repeat (2) @(negedge clk);
      k = $urandom_range(4, 0);
      n = $urandom_range(7, 0);
      flitId[k] = nocPkg::flitHeader;
      len[k] = nocPkg::lengthWidth'(n);
      req[k] = 1'b1;
      @(negedge clk);
      // A body flit with another length must not move the limit.
      flitId[k] = nocPkg::flitBody;
      len[k] = nocPkg::lengthWidth'(n + 3);
      held = 0;
      while (grant == stateOf(k) && held < 40)
      begin
        held++;
        @(negedge clk);
      end
      assert (held == n + 1)
      else
      begin
        $display("Fail at %0t: grant hold cycles expected %0d, got %0d", $time, n + 1, held);
        errorCount++;
      end
    end
    clearInputs();
    repeat (2) @(negedge clk);
    reportTest("hold length");

    startTest();
    for (int c = 0; c < 1000; c++)
    begin
      for (int p = 0; p < nocPkg::numPorts; p++)
      begin
        req[p] = ($urandom_range(3, 0) != 0);
        flitId[p] = nocPkg::flitIdT'($urandom_range(3, 0));
        len[p] = nocPkg::lengthWidth'($urandom_range(7, 0));
        flit[p] = $urandom;
      end
      @(negedge clk);
    end
    clearInputs();
    repeat (3) @(negedge clk);
    reportTest("forwarding");

    $display("Tests passed: %0d, failed: %0d", passedTests, failedTests);
    if (failedTests == 0 && errorCount == 0)
    begin
      $display("*** PASSED ***");
    end
    else
    begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// ==== bench/outputPort_assert.sv ====
module outputPortAssert
(
  input logic             clk,
  input logic             rst,
  input nocPkg::arbStateT grant,
  input logic             outValid
);

  // Each state bit is also a grant, so exactly one is set.
  grantOneHot: assert property (@(posedge clk) disable iff (rst) $onehot(grant))
    else $error("grant is not one-hot");

  validClearedByReset: assert property (@(posedge clk) rst |=> !outValid)
    else $error("outValid high after a reset cycle");

  // The mux registers the grant of the cycle before.
  validNeedsGrant: assert property (@(posedge clk) disable iff (rst)
    outValid |-> $past(grant) != nocPkg::stIdle)
    else $error("outValid high without a grant in the previous cycle");

endmodule

bind outputPort outputPortAssert outputPortAssert_inst
(
  .clk      (clk),
  .rst      (rst),
  .grant    (grant),
  .outValid (outValid)
);

// ==== common/nocPkg.sv ====
package nocPkg;

  // Link and packet widths.
  localparam int flitWidth = 32;
  localparam int lengthWidth = 12;
  localparam int flitIdWidth = 3;

  // Router inputs feeding this output port.
  localparam int numPorts = 5;

  // Position of a flit within its packet.
  typedef enum logic [flitIdWidth-1:0]
  {
    flitIdle   = 3'd0,
    flitHeader = 3'd1,
    flitBody   = 3'd2,
    flitTail   = 3'd3
  } flitIdT;

  // One-hot arbiter state, each port bit doubles as its grant.
  typedef enum logic [5:0]
  {
    stIdle  = 6'b000001,
    stLocal = 6'b000010,
    stNorth = 6'b000100,
    stEast  = 6'b001000,
    stWest  = 6'b010000,
    stSouth = 6'b100000
  } arbStateT;

  // Port index, also the search order from idle.
  // Port k owns bit k+1 of arbStateT.
  typedef enum logic [2:0]
  {
    portLocal = 3'd0,
    portNorth = 3'd1,
    portEast  = 3'd2,
    portWest  = 3'd3,
    portSouth = 3'd4
  } portT;

endpackage

// ==== hdl/flitMux.sv ====
module flitMux
(
  input  logic                         clk,
  input  logic                         rst,
  input  nocPkg::arbStateT             grant,
  input  logic [nocPkg::flitWidth-1:0] lFlit,
  input  logic [nocPkg::flitWidth-1:0] nFlit,
  input  logic [nocPkg::flitWidth-1:0] eFlit,
  input  logic [nocPkg::flitWidth-1:0] wFlit,
  input  logic [nocPkg::flitWidth-1:0] sFlit,
  input  logic                         lReq,
  input  logic                         nReq,
  input  logic                         eReq,
  input  logic                         wReq,
  input  logic                         sReq,
  output logic [nocPkg::flitWidth-1:0] outFlit,
  output logic                         outValid
);

  logic [nocPkg::flitWidth-1:0] flits [nocPkg::numPorts];
  logic [nocPkg::numPorts-1:0]  reqs;
  logic [nocPkg::flitWidth-1:0] selFlit;
  logic                         selValid;

  assign flits[nocPkg::portLocal] = lFlit;
  assign flits[nocPkg::portNorth] = nFlit;
  assign flits[nocPkg::portEast]  = eFlit;
  assign flits[nocPkg::portWest]  = wFlit;
  assign flits[nocPkg::portSouth] = sFlit;
  assign reqs = {sReq, wReq, eReq, nReq, lReq};

  // Grant bit k+1 selects port k; idle selects nothing.
  always_comb
  begin
    selFlit = '0;
    selValid = 1'b0;
    for (int k = 0; k < nocPkg::numPorts; k++)
    begin
      if (grant[k+1])
      begin
        selFlit = flits[k];
        selValid = reqs[k];
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outFlit <= '0;
      outValid <= 1'b0;
    end
    else
    begin
      outValid <= selValid;
      // Link data holds its last value while idle.
      if (grant != nocPkg::stIdle)
      begin
        outFlit <= selFlit;
      end
    end
  end

endmodule

// ==== hdl/outputPort.sv ====
module outputPort
(
  input  logic                           clk,
  input  logic                           rst,
  input  logic [nocPkg::flitWidth-1:0]   lFlit,
  input  logic [nocPkg::flitWidth-1:0]   nFlit,
  input  logic [nocPkg::flitWidth-1:0]   eFlit,
  input  logic [nocPkg::flitWidth-1:0]   wFlit,
  input  logic [nocPkg::flitWidth-1:0]   sFlit,
  input  nocPkg::flitIdT                 lFlitId,
  input  nocPkg::flitIdT                 nFlitId,
  input  nocPkg::flitIdT                 eFlitId,
  input  nocPkg::flitIdT                 wFlitId,
  input  nocPkg::flitIdT                 sFlitId,
  input  logic [nocPkg::lengthWidth-1:0] lLength,
  input  logic [nocPkg::lengthWidth-1:0] nLength,
  input  logic [nocPkg::lengthWidth-1:0] eLength,
  input  logic [nocPkg::lengthWidth-1:0] wLength,
  input  logic [nocPkg::lengthWidth-1:0] sLength,
  input  logic                           lReq,
  input  logic                           nReq,
  input  logic                           eReq,
  input  logic                           wReq,
  input  logic                           sReq,
  output nocPkg::arbStateT               grant,
  output logic [nocPkg::flitWidth-1:0]   outFlit,
  output logic                           outValid
);

  // Grant is registered here, the mux adds one more cycle.
  switchArbiter switchArbiter_inst
  (
    .clk     (clk),
    .rst     (rst),
    .lFlitId (lFlitId),
    .nFlitId (nFlitId),
    .eFlitId (eFlitId),
    .wFlitId (wFlitId),
    .sFlitId (sFlitId),
    .lLength (lLength),
    .nLength (nLength),
    .eLength (eLength),
    .wLength (wLength),
    .sLength (sLength),
    .lReq    (lReq),
    .nReq    (nReq),
    .eReq    (eReq),
    .wReq    (wReq),
    .sReq    (sReq),
    .grant   (grant)
  );

  flitMux flitMux_inst
  (
    .clk      (clk),
    .rst      (rst),
    .grant    (grant),
    .lFlit    (lFlit),
    .nFlit    (nFlit),
    .eFlit    (eFlit),
    .wFlit    (wFlit),
    .sFlit    (sFlit),
    .lReq     (lReq),
    .nReq     (nReq),
    .eReq     (eReq),
    .wReq     (wReq),
    .sReq     (sReq),
    .outFlit  (outFlit),
    .outValid (outValid)
  );

endmodule
